// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // data and address width
  localparam int word_w = 32;

  typedef logic [word_w-1:0] data_word_t;
  typedef logic [3:0] reg_num_t;
  typedef logic [3:0] cmd_code_t;
  typedef logic [1:0] reg_flags_t;

  // post-modify codes for a register field
  localparam reg_flags_t flag_keep = 2'b00;
  localparam reg_flags_t flag_inc = 2'b01;
  localparam reg_flags_t flag_dec = 2'b10;

  // r15 doubles as instruction pointer
  localparam reg_num_t reg_ip = 4'd15;

  // command word layout, lsb of each field
  localparam int s1_num_pos = 0;
  localparam int s0_num_pos = 4;
  localparam int dst_num_pos = 8;
  // pointer bits: s1, s0, dst from here up
  localparam int ptr_pos = 16;
  // two flag bits each: s1, s0, dst from here up
  localparam int flags_pos = 20;
  localparam int code_pos = 28;

  // operation presented to one slot
  typedef enum logic [2:0] {
    op_idle,
    op_read_reg,
    op_read_ptr,
    op_write_reg,
    op_write_ptr,
    op_load_result
  } slot_op_t;

  // which slot owns the memory port
  typedef enum logic [1:0] {
    slot_ip,
    slot_s1,
    slot_s0,
    slot_dst
  } slot_id_t;

endpackage

// ==== verilog/operand_slot.sv ====
module operand_slot import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  slot_op_t   slot_op,
  input  reg_num_t   reg_num,
  input  reg_flags_t flags,
  input  data_word_t reg_base,
  input  data_word_t rsp_data,
  input  data_word_t result,
  output data_word_t value,
  output data_word_t slot_addr,
  output data_word_t slot_wdata,
  output logic       slot_we
);

  // register content as read from memory
  data_word_t reg_val;
  // operand handed out, or the result to store
  data_word_t operand;
  // reg_val came from a register read this instruction
  logic reg_loaded;
  data_word_t adjusted;
  data_word_t reg_addr;

  assign reg_addr = reg_base + data_word_t'(reg_num);

  // post-modify of the held register
  always_comb begin
    case (flags)
      flag_inc: adjusted = reg_val + 1'b1;
      flag_dec: adjusted = reg_val - 1'b1;
      default: adjusted = reg_val;
    endcase
  end

  assign value = operand;

  always_comb begin
    slot_addr = reg_addr;
    slot_wdata = adjusted;
    slot_we = 1'b0;
    case (slot_op)
      // pointer accesses go through the register value
      op_read_ptr: slot_addr = reg_val;
      op_write_ptr: begin
        slot_addr = reg_val;
        slot_wdata = operand;
        slot_we = 1'b1;
      end
      op_write_reg: slot_we = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_loaded <= 1'b0;
    end else begin
      case (slot_op)
        op_read_reg: reg_loaded <= 1'b1;
        op_write_reg, op_write_ptr: reg_loaded <= 1'b0;
        default: ;
      endcase
    end
  end

  // rsp_data is sampled every cycle of a read, last sample is the answer
  always_ff @(posedge clk) begin
    case (slot_op)
      op_read_reg: begin
        reg_val <= rsp_data;
        operand <= rsp_data;
      end
      op_read_ptr: operand <= rsp_data;
      op_load_result: begin
        operand <= result;
        // direct dst: result becomes the register before post-modify
        if (!reg_loaded) reg_val <= result;
      end
      default: ;
    endcase
  end

  // keep-flag write-back only stores a direct alu result
  assert property (@(posedge clk) disable iff (rst)
    (slot_op == op_write_reg && flags != flag_inc && flags != flag_dec) |-> !reg_loaded);

endmodule

// ==== verilog/fetch_sequencer.sv ====
module fetch_sequencer import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       exec_valid,
  output logic       exec_ready,
  input  data_word_t command_word,
  output logic       op_valid,
  input  logic       op_ready,
  input  logic       res_valid,
  output logic       res_ready,
  input  logic       req_done,
  output logic       req_start,
  output slot_id_t   sel_slot,
  output slot_op_t   ip_op,
  output slot_op_t   s1_op,
  output slot_op_t   s0_op,
  output slot_op_t   dst_op
);

  typedef enum logic [3:0] {
    st_idle,
    st_ip_rd,
    st_cmd_rd,
    st_ip_wr,
    st_s1_rd,
    st_s1_ptr,
    st_s1_wr,
    st_s0_rd,
    st_s0_ptr,
    st_s0_wr,
    st_dst_rd,
    st_ops,
    st_res,
    st_dst_ptr,
    st_dst_wr
  } state_t;

  state_t state, state_nxt;
  // request of the current step already sent
  logic issued;
  logic mem_step;

  logic s1_ptr, s0_ptr, dst_ptr;
  logic s1_adj, s0_adj, dst_adj;
  reg_flags_t s1_flags, s0_flags, dst_flags;

  // decode, only meaningful after the command read
  assign s1_ptr = command_word[ptr_pos];
  assign s0_ptr = command_word[ptr_pos+1];
  assign dst_ptr = command_word[ptr_pos+2];
  assign s1_flags = command_word[flags_pos +: 2];
  assign s0_flags = command_word[flags_pos+2 +: 2];
  assign dst_flags = command_word[flags_pos+4 +: 2];
  // a write-back step exists only for inc or dec
  assign s1_adj = (s1_flags == flag_inc) || (s1_flags == flag_dec);
  assign s0_adj = (s0_flags == flag_inc) || (s0_flags == flag_dec);
  assign dst_adj = (dst_flags == flag_inc) || (dst_flags == flag_dec);

  // handshakes straight from state
  assign exec_ready = (state == st_idle);
  assign op_valid = (state == st_ops);
  assign res_ready = (state == st_res);

  assign mem_step = !(state inside {st_idle, st_ops, st_res});
  assign req_start = mem_step && !issued;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      issued <= 1'b0;
    end else begin
      state <= state_nxt;
      if (req_done) begin
        issued <= 1'b0;
      end else if (req_start) begin
        issued <= 1'b1;
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: if (exec_valid) state_nxt = st_ip_rd;
      st_ip_rd: if (req_done) state_nxt = st_cmd_rd;
      st_cmd_rd: if (req_done) state_nxt = st_ip_wr;
      st_ip_wr: if (req_done) state_nxt = st_s1_rd;
      // source 1 first
      st_s1_rd: begin
        if (req_done) begin
          if (s1_ptr) state_nxt = st_s1_ptr;
          else if (s1_adj) state_nxt = st_s1_wr;
          else state_nxt = st_s0_rd;
        end
      end
      st_s1_ptr: if (req_done) state_nxt = s1_adj ? st_s1_wr : st_s0_rd;
      st_s1_wr: if (req_done) state_nxt = st_s0_rd;
      // then source 0, sees source 1 write-back through memory
      st_s0_rd: begin
        if (req_done) begin
          if (s0_ptr) state_nxt = st_s0_ptr;
          else if (s0_adj) state_nxt = st_s0_wr;
          else state_nxt = dst_ptr ? st_dst_rd : st_ops;
        end
      end
      st_s0_ptr: begin
        if (req_done) begin
          if (s0_adj) state_nxt = st_s0_wr;
          else state_nxt = dst_ptr ? st_dst_rd : st_ops;
        end
      end
      st_s0_wr: if (req_done) state_nxt = dst_ptr ? st_dst_rd : st_ops;
      // pointer dst needs its register before the result arrives
      st_dst_rd: if (req_done) state_nxt = st_ops;
      st_ops: if (op_ready) state_nxt = st_res;
      st_res: if (res_valid) state_nxt = dst_ptr ? st_dst_ptr : st_dst_wr;
      st_dst_ptr: if (req_done) state_nxt = dst_adj ? st_dst_wr : st_idle;
      st_dst_wr: if (req_done) state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  // slot operations and port owner per state
  always_comb begin
    ip_op = op_idle;
    s1_op = op_idle;
    s0_op = op_idle;
    dst_op = op_idle;
    sel_slot = slot_ip;
    case (state)
      st_ip_rd: ip_op = op_read_reg;
      st_cmd_rd: ip_op = op_read_ptr;
      st_ip_wr: ip_op = op_write_reg;
      st_s1_rd: begin
        s1_op = op_read_reg;
        sel_slot = slot_s1;
      end
      st_s1_ptr: begin
        s1_op = op_read_ptr;
        sel_slot = slot_s1;
      end
      st_s1_wr: begin
        s1_op = op_write_reg;
        sel_slot = slot_s1;
      end
      st_s0_rd: begin
        s0_op = op_read_reg;
        sel_slot = slot_s0;
      end
      st_s0_ptr: begin
        s0_op = op_read_ptr;
        sel_slot = slot_s0;
      end
      st_s0_wr: begin
        s0_op = op_write_reg;
        sel_slot = slot_s0;
      end
      st_dst_rd: begin
        dst_op = op_read_reg;
        sel_slot = slot_dst;
      end
      // result taken on the res handshake edge
      st_res: begin
        if (res_valid) dst_op = op_load_result;
        sel_slot = slot_dst;
      end
      st_dst_ptr: begin
        dst_op = op_write_ptr;
        sel_slot = slot_dst;
      end
      st_dst_wr: begin
        dst_op = op_write_reg;
        sel_slot = slot_dst;
      end
      default: ;
    endcase
  end

  // one transaction in flight at a time
  assert property (@(posedge clk) disable iff (rst)
    req_start |=> (!req_start until_with req_done));

endmodule

// ==== verilog/mem_port.sv ====
module mem_port import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  slot_id_t   sel_slot,
  input  logic       req_start,
  input  data_word_t ip_addr,
  input  data_word_t s1_addr,
  input  data_word_t s0_addr,
  input  data_word_t dst_addr,
  input  data_word_t ip_wdata,
  input  data_word_t s1_wdata,
  input  data_word_t s0_wdata,
  input  data_word_t dst_wdata,
  input  logic       ip_we,
  input  logic       s1_we,
  input  logic       s0_we,
  input  logic       dst_we,
  output logic       req_done,
  output data_word_t rsp_data,
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output logic       mem_we,
  output data_word_t mem_addr,
  output data_word_t mem_wdata,
  input  logic       mem_rsp_valid,
  input  data_word_t mem_rdata
);

  data_word_t sel_addr, sel_wdata;
  logic sel_we;
  // read accepted, answer pending
  logic wait_rsp;

  always_comb begin
    case (sel_slot)
      slot_ip: {sel_addr, sel_wdata, sel_we} = {ip_addr, ip_wdata, ip_we};
      slot_s1: {sel_addr, sel_wdata, sel_we} = {s1_addr, s1_wdata, s1_we};
      slot_s0: {sel_addr, sel_wdata, sel_we} = {s0_addr, s0_wdata, s0_we};
      default: {sel_addr, sel_wdata, sel_we} = {dst_addr, dst_wdata, dst_we};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_valid <= 1'b0;
      wait_rsp <= 1'b0;
      req_done <= 1'b0;
    end else begin
      req_done <= 1'b0;
      if (req_start) begin
        mem_req_valid <= 1'b1;
      end else if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
        // writes finish on acceptance
        if (mem_we) req_done <= 1'b1;
        else wait_rsp <= 1'b1;
      end
      if (wait_rsp && mem_rsp_valid) begin
        wait_rsp <= 1'b0;
        req_done <= 1'b1;
      end
    end
  end

  // request payload frozen from start to acceptance
  always_ff @(posedge clk) begin
    if (req_start) begin
      mem_addr <= sel_addr;
      mem_wdata <= sel_wdata;
      mem_we <= sel_we;
    end
    if (wait_rsp && mem_rsp_valid) rsp_data <= mem_rdata;
  end

  assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_addr)));

endmodule

// ==== verilog/operand_fetch_unit.sv ====
module operand_fetch_unit import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  data_word_t reg_base,
  // instruction start
  input  logic       exec_valid,
  output logic       exec_ready,
  // operands to the alu side
  output logic       op_valid,
  input  logic       op_ready,
  output data_word_t src1_value,
  output data_word_t src0_value,
  output cmd_code_t  cmd_code,
  // result back from the alu side
  input  logic       res_valid,
  output logic       res_ready,
  input  data_word_t result_value,
  // memory port
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output logic       mem_we,
  output data_word_t mem_addr,
  output data_word_t mem_wdata,
  input  logic       mem_rsp_valid,
  input  data_word_t mem_rdata
);

  data_word_t command_word;
  slot_op_t   ip_op, s1_op, s0_op, dst_op;
  slot_id_t   sel_slot;
  logic       req_start, req_done;
  data_word_t rsp_data;

  data_word_t ip_addr, s1_addr, s0_addr, dst_addr;
  data_word_t ip_wdata, s1_wdata, s0_wdata, dst_wdata;
  logic       ip_we, s1_we, s0_we, dst_we;

  // fetched word sits in the ip slot operand
  assign cmd_code = command_word[code_pos +: 4];

  fetch_sequencer fetch_sequencer_i (
    .clk(clk), .rst(rst),
    .exec_valid(exec_valid), .exec_ready(exec_ready),
    .command_word(command_word),
    .op_valid(op_valid), .op_ready(op_ready),
    .res_valid(res_valid), .res_ready(res_ready),
    .req_done(req_done), .req_start(req_start), .sel_slot(sel_slot),
    .ip_op(ip_op), .s1_op(s1_op), .s0_op(s0_op), .dst_op(dst_op)
  );

  // ip is always pointer-read and post-incremented
  operand_slot ip_slot (
    .clk(clk), .rst(rst), .slot_op(ip_op), .reg_num(reg_ip), .flags(flag_inc),
    .reg_base(reg_base), .rsp_data(rsp_data), .result(result_value),
    .value(command_word), .slot_addr(ip_addr), .slot_wdata(ip_wdata), .slot_we(ip_we)
  );

  operand_slot s1_slot (
    .clk(clk), .rst(rst), .slot_op(s1_op), .reg_num(command_word[s1_num_pos +: 4]),
    .flags(command_word[flags_pos +: 2]),
    .reg_base(reg_base), .rsp_data(rsp_data), .result(result_value),
    .value(src1_value), .slot_addr(s1_addr), .slot_wdata(s1_wdata), .slot_we(s1_we)
  );

  operand_slot s0_slot (
    .clk(clk), .rst(rst), .slot_op(s0_op), .reg_num(command_word[s0_num_pos +: 4]),
    .flags(command_word[flags_pos+2 +: 2]),
    .reg_base(reg_base), .rsp_data(rsp_data), .result(result_value),
    .value(src0_value), .slot_addr(s0_addr), .slot_wdata(s0_wdata), .slot_we(s0_we)
  );

  // dst operand holds the captured alu result
  operand_slot dst_slot (
    .clk(clk), .rst(rst), .slot_op(dst_op), .reg_num(command_word[dst_num_pos +: 4]),
    .flags(command_word[flags_pos+4 +: 2]),
    .reg_base(reg_base), .rsp_data(rsp_data), .result(result_value),
    .value(), .slot_addr(dst_addr), .slot_wdata(dst_wdata), .slot_we(dst_we)
  );

  mem_port mem_port_i (
    .clk(clk), .rst(rst), .sel_slot(sel_slot), .req_start(req_start),
    .ip_addr(ip_addr), .s1_addr(s1_addr), .s0_addr(s0_addr), .dst_addr(dst_addr),
    .ip_wdata(ip_wdata), .s1_wdata(s1_wdata), .s0_wdata(s0_wdata), .dst_wdata(dst_wdata),
    .ip_we(ip_we), .s1_we(s1_we), .s0_we(s0_we), .dst_we(dst_we),
    .req_done(req_done), .rsp_data(rsp_data),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
  );

endmodule

// ==== dv/tb_mem_model.sv ====
module tb_mem_model import fetch_pkg::*; #(
  parameter int depth = 1024
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       mem_req_valid,
  output logic       mem_req_ready,
  input  logic       mem_we,
  input  data_word_t mem_addr,
  input  data_word_t mem_wdata,
  output logic       mem_rsp_valid,
  output data_word_t mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  // word storage, addresses wrap at depth
  data_word_t mem [depth];

  int seed;
  // accepted read still waiting for its answer
  logic pend;
  data_word_t pend_addr;
  // cycles left before the answer goes out
  int delay;

  initial begin
    seed = 30;
    pend = 1'b0;
    pend_addr = '0;
    delay = 0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata = '0;
  end

  // requests and answers are taken on the rising edge
  always @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
    end else begin
      // answer consumed on this edge
      if (mem_rsp_valid) begin
        pend <= 1'b0;
      end else if (pend && delay > 0) begin
        delay <= delay - 1;
      end
      if (mem_req_valid && mem_req_ready) begin
        if (mem_we) begin
          mem[mem_addr % depth] = mem_wdata;
        end else begin
          pend <= 1'b1;
          pend_addr <= mem_addr;
          delay <= $unsigned($random(seed)) % 4;
        end
      end
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    // ready about three cycles in four
    mem_req_ready = ($random(seed) & 3) != 0;
    mem_rsp_valid = pend && (delay == 0);
    mem_rdata = mem[pend_addr % depth];
  end

endmodule

// ==== dv/tb_operand_fetch.sv ====
module tb_operand_fetch import fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words = 1024;
  localparam int n_rows = 12;
  localparam int clk_period = 10;
  // budget per table row
  localparam int row_cycles = 400;
  localparam data_word_t base_addr = 32'h0000_0100;
  localparam data_word_t ip_start = 32'h0000_0200;

  // one instruction with its register setup and alu answer
  typedef struct packed {
    reg_num_t s1_num;
    reg_num_t s0_num;
    reg_num_t dst_num;
    logic [2:0] ptr;
    reg_flags_t s1_flags;
    reg_flags_t s0_flags;
    reg_flags_t dst_flags;
    cmd_code_t code;
    data_word_t s1_init;
    data_word_t s0_init;
    data_word_t dst_init;
    data_word_t s1_data;
    data_word_t s0_data;
    data_word_t result;
  } row_t;

  logic clk = 1'b0;
  logic rst;
  data_word_t reg_base;
  logic exec_valid, exec_ready;
  logic op_valid, op_ready;
  data_word_t src1_value, src0_value;
  cmd_code_t cmd_code;
  logic res_valid, res_ready;
  data_word_t result_value;
  logic mem_req_valid, mem_req_ready, mem_we;
  data_word_t mem_addr, mem_wdata;
  logic mem_rsp_valid;
  data_word_t mem_rdata;

  row_t rows [n_rows];
  // expected memory image, updated in instruction order
  data_word_t ref_mem [mem_words];
  int op_seed;

  always #(clk_period / 2) clk = ~clk;

  operand_fetch_unit operand_fetch_unit_i (
    .clk(clk), .rst(rst), .reg_base(reg_base),
    .exec_valid(exec_valid), .exec_ready(exec_ready),
    .op_valid(op_valid), .op_ready(op_ready),
    .src1_value(src1_value), .src0_value(src0_value), .cmd_code(cmd_code),
    .res_valid(res_valid), .res_ready(res_ready), .result_value(result_value),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
  );

  tb_mem_model #(.depth(mem_words)) mem_model (
    .clk(clk), .rst(rst), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input cmd_code_t got, input cmd_code_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s: got 0x%01h, expected 0x%01h", name, got, exp));
    end
  endtask

  function automatic int mem_index(input data_word_t a);
    return int'(a % mem_words);
  endfunction

  function automatic data_word_t adjust_value(input data_word_t v, input reg_flags_t f);
    if (f == flag_inc) return v + 1;
    if (f == flag_dec) return v - 1;
    return v;
  endfunction

  // only inc and dec cause a register write-back
  function automatic logic writes_back(input reg_flags_t f);
    return (f == flag_inc) || (f == flag_dec);
  endfunction

  function automatic data_word_t build_command(input row_t r);
    data_word_t w;
    w = '0;
    w[s1_num_pos +: 4] = r.s1_num;
    w[s0_num_pos +: 4] = r.s0_num;
    w[dst_num_pos +: 4] = r.dst_num;
    w[ptr_pos +: 3] = r.ptr;
    w[flags_pos +: 2] = r.s1_flags;
    w[flags_pos+2 +: 2] = r.s0_flags;
    w[flags_pos+4 +: 2] = r.dst_flags;
    w[code_pos +: 4] = r.code;
    return w;
  endfunction

  // same word lands in the model and in the expected image
  task automatic preload_word(input data_word_t a, input data_word_t d);
    mem_model.mem[mem_index(a)] = d;
    ref_mem[mem_index(a)] = d;
  endtask

  task automatic resolve_source(input reg_num_t n, input logic ptr, input reg_flags_t f,
                                output data_word_t operand);
    data_word_t reg_addr;
    data_word_t reg_val;
    reg_addr = base_addr + n;
    reg_val = ref_mem[mem_index(reg_addr)];
    operand = ptr ? ref_mem[mem_index(reg_val)] : reg_val;
    if (writes_back(f)) ref_mem[mem_index(reg_addr)] = adjust_value(reg_val, f);
  endtask

  // ip, src1, src0, dst strictly in that order
  task automatic model_instruction(input row_t r, output data_word_t s1_exp,
                                   output data_word_t s0_exp);
    data_word_t ip_addr;
    data_word_t dst_addr;
    data_word_t dst_val;
    ip_addr = base_addr + reg_ip;
    ref_mem[mem_index(ip_addr)] = ref_mem[mem_index(ip_addr)] + 1;
    resolve_source(r.s1_num, r.ptr[0], r.s1_flags, s1_exp);
    resolve_source(r.s0_num, r.ptr[1], r.s0_flags, s0_exp);
    dst_addr = base_addr + r.dst_num;
    if (r.ptr[2]) begin
      dst_val = ref_mem[mem_index(dst_addr)];
      ref_mem[mem_index(dst_val)] = r.result;
      if (writes_back(r.dst_flags)) begin
        ref_mem[mem_index(dst_addr)] = adjust_value(dst_val, r.dst_flags);
      end
    end else begin
      ref_mem[mem_index(dst_addr)] = adjust_value(r.result, r.dst_flags);
    end
  endtask

  // random op_ready, operands checked on every cycle op_valid is up
  task automatic take_operands(input cmd_code_t code, input data_word_t s1_exp,
                               input data_word_t s0_exp);
    logic ready_now;
    do begin
      @(negedge clk);
      if (op_valid) begin
        check_word("src1_value", src1_value, s1_exp);
        check_word("src0_value", src0_value, s0_exp);
        check_code("cmd_code", cmd_code, code);
      end
      ready_now = ($random(op_seed) & 1) != 0;
      op_ready = ready_now;
    end while (!(op_valid && ready_now));
  endtask

  task automatic give_result(input data_word_t res);
    @(negedge clk);
    op_ready = 1'b0;
    repeat ($unsigned($random(op_seed)) % 3) @(negedge clk);
    res_valid = 1'b1;
    result_value = res;
    while (!res_ready) @(negedge clk);
    @(negedge clk);
    res_valid = 1'b0;
    // junk after the handshake must not reach memory
    result_value = ~res;
  endtask

  task automatic run_row(input int i);
    row_t r;
    data_word_t ip_val;
    data_word_t s1_exp;
    data_word_t s0_exp;
    r = rows[i];
    @(negedge clk);
    preload_word(base_addr + r.s1_num, r.s1_init);
    preload_word(base_addr + r.s0_num, r.s0_init);
    preload_word(base_addr + r.dst_num, r.dst_init);
    if (r.ptr[0]) preload_word(r.s1_init, r.s1_data);
    if (r.ptr[1]) preload_word(r.s0_init, r.s0_data);
    ip_val = ref_mem[mem_index(base_addr + reg_ip)];
    preload_word(ip_val, build_command(r));
    model_instruction(r, s1_exp, s0_exp);
    exec_valid = 1'b1;
    while (!exec_ready) @(negedge clk);
    @(negedge clk);
    exec_valid = 1'b0;
    take_operands(r.code, s1_exp, s0_exp);
    give_result(r.result);
    while (!exec_ready) @(negedge clk);
    // one word per instruction from ip_start on
    check_word("ip", mem_model.mem[mem_index(base_addr + reg_ip)], ip_start + i + 1);
    for (int a = 0; a < mem_words; a++) begin
      check_word($sformatf("mem[%03h]", a), mem_model.mem[a], ref_mem[a]);
    end
  endtask

  task automatic fill_table();
    // direct sources, keep flags
    rows[0] = {4'd1, 4'd2, 4'd3, 3'b000, flag_keep, flag_keep, flag_keep, 4'h1,
      32'h1111_1111, 32'h2222_2222, 32'h0, 32'h0, 32'h0, 32'hdead_0001};
    // src1 through pointer
    rows[1] = {4'd4, 4'd5, 4'd6, 3'b001, flag_keep, flag_keep, flag_keep, 4'h2,
      32'h310, 32'h5555, 32'h77, 32'ha5a5_0001, 32'h0, 32'h0bad_0002};
    rows[2] = {4'd1, 4'd2, 4'd4, 3'b011, flag_keep, flag_keep, flag_keep, 4'h3,
      32'h320, 32'h330, 32'h88, 32'hc0de_0003, 32'hface_0004, 32'h1234_0005};
    // source post-modify
    rows[3] = {4'd5, 4'd6, 4'd7, 3'b000, flag_inc, flag_dec, flag_keep, 4'h4,
      32'h40, 32'h80, 32'h0, 32'h0, 32'h0, 32'h0000_abcd};
    // same register twice, second read sees first increment
    rows[4] = {4'd7, 4'd7, 4'd8, 3'b000, flag_inc, flag_inc, flag_keep, 4'h5,
      32'h50, 32'h60, 32'h0, 32'h0, 32'h0, 32'h5555_0006};
    rows[5] = {4'd8, 4'd8, 4'd9, 3'b011, flag_inc, flag_keep, flag_keep, 4'h6,
      32'h340, 32'h344, 32'h0, 32'h1111_aaaa, 32'h2222_bbbb, 32'h0006_0006};
    // pointer destinations
    rows[6] = {4'd9, 4'd1, 4'd10, 3'b100, flag_keep, flag_keep, flag_keep, 4'h7,
      32'h99, 32'h1, 32'h350, 32'h0, 32'h0, 32'h7777_0007};
    rows[7] = {4'd2, 4'd3, 4'd10, 3'b100, flag_keep, flag_keep, flag_inc, 4'h8,
      32'h2, 32'h3, 32'h358, 32'h0, 32'h0, 32'h8888_0008};
    rows[8] = {4'd3, 4'd4, 4'd11, 3'b000, flag_keep, flag_keep, flag_dec, 4'h9,
      32'h3, 32'h4, 32'h0, 32'h0, 32'h0, 32'h9999_0009};
    // dst shares its register with src1
    rows[9] = {4'd12, 4'd1, 4'd12, 3'b000, flag_inc, flag_keep, flag_inc, 4'ha,
      32'h1000, 32'h1, 32'h1000, 32'h0, 32'h0, 32'haaaa_000a};
    rows[10] = {4'd13, 4'd2, 4'd13, 3'b101, flag_inc, flag_keep, flag_dec, 4'hb,
      32'h360, 32'h2, 32'h360, 32'hbbbb_0001, 32'h0, 32'hbbbb_000b};
    rows[11] = {4'd14, 4'd0, 4'd6, 3'b111, flag_dec, flag_inc, flag_inc, 4'hf,
      32'h370, 32'h378, 32'h380, 32'hcccc_0001, 32'hdddd_0002, 32'heeee_000f};
  endtask

  initial begin
    rst = 1'b1;
    reg_base = base_addr;
    exec_valid = 1'b0;
    op_ready = 1'b0;
    res_valid = 1'b0;
    result_value = '0;
    op_seed = 30;
    fill_table();
    // every word distinct, so a wrong address shows up
    for (int a = 0; a < mem_words; a++) begin
      preload_word(a, data_word_t'(a) * 32'h9e37_79b1);
    end
    preload_word(base_addr + reg_ip, ip_start);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("Regression passed");
    $finish;
  end

  initial begin
    repeat (n_rows * row_cycles) @(posedge clk);
    stop_on_error($sformatf("timeout after %0d cycles, the DUT stopped making progress",
      n_rows * row_cycles));
  end

endmodule

// ==== files.f ====
verilog/fetch_pkg.sv
verilog/operand_slot.sv
verilog/fetch_sequencer.sv
verilog/mem_port.sv
verilog/operand_fetch_unit.sv
dv/tb_mem_model.sv
dv/tb_operand_fetch.sv
